// ==== common/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define XLEN        32
`define IMEM_DEPTH  256                  // Instruction words
`define DMEM_DEPTH  256                  // Data words
`define REG_COUNT   32
`define REG_ADDR_W  5
`define IMEM_AW     $clog2(`IMEM_DEPTH)  // Word address width
`define DMEM_AW     $clog2(`DMEM_DEPTH)

`endif

// ==== common/cpu_pkg.sv ====
`include "cpu_params.svh"

package cpu_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_R     = 7'b0110011,
        OP_IMM   = 7'b0010011,
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,  // Signed compare
        SLTU   = 4'd4,  // Unsigned compare
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,  // Arithmetic shift
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10  // Operand b straight through
    } alu_op_e;

    // Control word handed from decode to execute
    typedef struct packed {
        alu_op_e                alu_op;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   reg_we;
        logic                   mem_re;
        logic                   mem_we;
        logic                   use_imm;  // Operand b from immediate
    } decoded_t;

endpackage

// ==== common/dec_if.sv ====
`include "cpu_params.svh"

// Decoded instruction and operands, valid for the whole cycle
interface dec_if import cpu_pkg::*; ();

    decoded_t           ctrl;
    logic [`XLEN-1:0]   rs1_data;
    logic [`XLEN-1:0]   rs2_data;
    logic [`XLEN-1:0]   imm;  // Already sign extended

    modport decode (
        output ctrl,
        output rs1_data,
        output rs2_data,
        output imm
    );

    modport execute (
        input ctrl,
        input rs1_data,
        input rs2_data,
        input imm
    );

endinterface

// ==== hw/fetch_stage.sv ====
`include "cpu_params.svh"

module fetch_stage (
    input  logic                  CLK,
    input  logic                  RST,
    input  logic                  run,
    input  logic                  imem_we,
    input  logic [`IMEM_AW-1:0]   imem_addr,
    input  logic [`XLEN-1:0]      imem_wdata,
    output logic [`XLEN-1:0]      instr,
    output logic [`XLEN-1:0]      pc
);

    logic [`XLEN-1:0] imem [`IMEM_DEPTH];  // No reset, loaded while halted

    // Program load port, locked out while the core runs
    always_ff @(posedge CLK) begin
        if (imem_we && !run) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc + `XLEN'(4);  // One instruction per edge
        end
    end

    // Word index from the byte pc
    assign instr = imem[pc[`IMEM_AW+1:2]];

endmodule

// ==== hw/register_file.sv ====
`include "cpu_params.svh"

module register_file (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic [`REG_ADDR_W-1:0]  rs1_addr,
    input  logic [`REG_ADDR_W-1:0]  rs2_addr,
    input  logic                    wb_we,
    input  logic [`REG_ADDR_W-1:0]  wb_rd,
    input  logic [`XLEN-1:0]        wb_data,
    output logic [`XLEN-1:0]        rs1_data,
    output logic [`XLEN-1:0]        rs2_data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin  // x0 never written
            regs[wb_rd] <= wb_data;
        end
    end

    // Asynchronous reads, x0 forced to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== hw/decode_stage.sv ====
`include "cpu_params.svh"

module decode_stage import cpu_pkg::*; (
    input  logic [`XLEN-1:0]        instr,
    output logic [`REG_ADDR_W-1:0]  rs1_addr,
    output logic [`REG_ADDR_W-1:0]  rs2_addr,
    input  logic [`XLEN-1:0]        rs1_data,
    input  logic [`XLEN-1:0]        rs2_data,
    dec_if.decode                   dec
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [`REG_ADDR_W-1:0]  rd;
    logic [`XLEN-1:0]        imm_i;
    logic [`XLEN-1:0]        imm_s;
    decoded_t                ctrl;
    logic [`XLEN-1:0]        imm;

    assign opcode   = instr[6:0];
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign funct7   = instr[31:25];

    assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};

    always_comb begin
        // Default is a no-op with every enable cleared
        ctrl = '{alu_op: PASS_B, rd: '0, reg_we: 1'b0, mem_re: 1'b0,
                 mem_we: 1'b0, use_imm: 1'b0};
        imm  = '0;
        case (opcode)
            OP_R: begin
                if (funct7 == 7'b0000000) begin
                    ctrl.reg_we = 1'b1;
                    case (funct3)
                        3'b000: ctrl.alu_op = ADD;
                        3'b001: ctrl.alu_op = SLL;
                        3'b010: ctrl.alu_op = SLT;
                        3'b011: ctrl.alu_op = SLTU;
                        3'b100: ctrl.alu_op = XOR;
                        3'b101: ctrl.alu_op = SRL;
                        3'b110: ctrl.alu_op = OR;
                        default: ctrl.alu_op = AND;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    ctrl.alu_op = SUB;
                    ctrl.reg_we = 1'b1;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
                    ctrl.alu_op = SRA;
                    ctrl.reg_we = 1'b1;
                end
                ctrl.rd = ctrl.reg_we ? rd : '0;
            end
            OP_IMM: begin
                imm = imm_i;  // Shifts only look at the low five bits
                ctrl.use_imm = 1'b1;
                if (funct3 == 3'b000) begin
                    ctrl.alu_op = ADD;
                    ctrl.reg_we = 1'b1;
                end else if (funct3 == 3'b001 && funct7 == 7'b0000000) begin
                    ctrl.alu_op = SLL;
                    ctrl.reg_we = 1'b1;
                end else if (funct3 == 3'b101 && funct7 == 7'b0000000) begin
                    ctrl.alu_op = SRL;
                    ctrl.reg_we = 1'b1;
                end else if (funct3 == 3'b101 && funct7 == 7'b0100000) begin
                    ctrl.alu_op = SRA;
                    ctrl.reg_we = 1'b1;
                end
                ctrl.rd = ctrl.reg_we ? rd : '0;
            end
            OP_LOAD: begin
                if (funct3 == 3'b010) begin  // lw only
                    imm          = imm_i;
                    ctrl.alu_op  = ADD;
                    ctrl.rd      = rd;
                    ctrl.reg_we  = 1'b1;
                    ctrl.mem_re  = 1'b1;
                    ctrl.use_imm = 1'b1;
                end
            end
            OP_STORE: begin
                if (funct3 == 3'b010) begin  // sw only
                    imm          = imm_s;
                    ctrl.alu_op  = ADD;
                    ctrl.mem_we  = 1'b1;
                    ctrl.use_imm = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign dec.ctrl     = ctrl;
    assign dec.imm      = imm;
    assign dec.rs1_data = rs1_data;
    assign dec.rs2_data = rs2_data;

endmodule

// ==== hw/execute_stage.sv ====
`include "cpu_params.svh"

module execute_stage import cpu_pkg::*; (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    run,
    dec_if.execute                  dec,
    output logic                    wb_we,
    output logic [`REG_ADDR_W-1:0]  wb_rd,
    output logic [`XLEN-1:0]        wb_data,
    output logic                    retire_valid,
    output logic                    retire_store,
    output logic [`REG_ADDR_W-1:0]  retire_rd,
    output logic [`XLEN-1:0]        retire_data
);

    logic [`XLEN-1:0]       operand_b;
    logic [4:0]             shamt;
    logic [`XLEN-1:0]       alu_result;
    logic [`DMEM_AW-1:0]    dmem_idx;
    logic [`XLEN-1:0]       load_data;
    logic [`XLEN-1:0]       dmem [`DMEM_DEPTH];

    assign operand_b = dec.ctrl.use_imm ? dec.imm : dec.rs2_data;
    assign shamt     = operand_b[4:0];

    always_comb begin
        case (dec.ctrl.alu_op)
            ADD:     alu_result = dec.rs1_data + operand_b;
            SUB:     alu_result = dec.rs1_data - operand_b;
            SLL:     alu_result = dec.rs1_data << shamt;
            SLT:     alu_result = `XLEN'($signed(dec.rs1_data) < $signed(operand_b));
            SLTU:    alu_result = `XLEN'(dec.rs1_data < operand_b);
            XOR:     alu_result = dec.rs1_data ^ operand_b;
            SRL:     alu_result = dec.rs1_data >> shamt;
            SRA:     alu_result = `XLEN'($signed(dec.rs1_data) >>> shamt);
            OR:      alu_result = dec.rs1_data | operand_b;
            AND:     alu_result = dec.rs1_data & operand_b;
            PASS_B:  alu_result = operand_b;
            default: alu_result = '0;
        endcase
    end

    // Word addressed, byte offset dropped
    assign dmem_idx  = alu_result[`DMEM_AW+1:2];
    assign load_data = dmem[dmem_idx];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (run && dec.ctrl.mem_we) begin
            dmem[dmem_idx] <= dec.rs2_data;
        end
    end

    assign wb_we   = run && dec.ctrl.reg_we;
    assign wb_rd   = dec.ctrl.rd;
    assign wb_data = dec.ctrl.mem_re ? load_data : alu_result;

    always_ff @(posedge CLK) begin
        if (RST) begin
            retire_valid <= 1'b0;
            retire_store <= 1'b0;
        end else begin
            retire_valid <= run;  // One pulse per executed instruction
            retire_store <= run && dec.ctrl.mem_we;
        end
    end

    // Payload only, follows retire_valid
    always_ff @(posedge CLK) begin
        if (run) begin
            if (dec.ctrl.reg_we && dec.ctrl.rd != '0) begin
                retire_rd   <= dec.ctrl.rd;
                retire_data <= wb_data;
            end else if (dec.ctrl.mem_we) begin
                retire_rd   <= '0;
                retire_data <= dec.rs2_data;  // Stored word
            end else begin
                retire_rd   <= '0;  // No-op or write to x0
                retire_data <= '0;
            end
        end
    end

endmodule

// ==== hw/single_cycle_cpu.sv ====
`include "cpu_params.svh"

module single_cycle_cpu (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    run,
    input  logic                    imem_we,
    input  logic [`IMEM_AW-1:0]     imem_addr,
    input  logic [`XLEN-1:0]        imem_wdata,
    output logic                    retire_valid,
    output logic                    retire_store,
    output logic [`REG_ADDR_W-1:0]  retire_rd,
    output logic [`XLEN-1:0]        retire_data
);

    logic [`XLEN-1:0]       instr;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic                   wb_we;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0]       wb_data;

    dec_if dec_bus ();

    fetch_stage u_fetch (
        .CLK        (CLK),
        .RST        (RST),
        .run        (run),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .instr      (instr),
        .pc         ()  // Only used inside fetch for now
    );

    decode_stage u_decode (
        .instr      (instr),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .dec        (dec_bus.decode)
    );

    register_file u_regs (
        .CLK        (CLK),
        .RST        (RST),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .wb_we      (wb_we),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    execute_stage u_execute (
        .CLK          (CLK),
        .RST          (RST),
        .run          (run),
        .dec          (dec_bus.execute),
        .wb_we        (wb_we),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .retire_valid (retire_valid),
        .retire_store (retire_store),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

// ==== verification/cpu_assert.sv ====
`include "cpu_params.svh"

module cpu_assert (
    input logic                    CLK,
    input logic                    RST,
    input logic                    run,
    input logic                    retire_valid,
    input logic                    retire_store,
    input logic [`REG_ADDR_W-1:0]  retire_rd,
    input logic [`XLEN-1:0]        retire_data
);

    halted_no_retire: assert property (@(posedge CLK) disable iff (RST)
        !run |=> !retire_valid)
        else $error("retire_valid high in the cycle after a halted cycle");

    store_rd_zero: assert property (@(posedge CLK) disable iff (RST)
        retire_store |-> retire_rd == '0)
        else $error("retire_rd nonzero on a store");

    data_known: assert property (@(posedge CLK) disable iff (RST)
        retire_valid |-> !$isunknown(retire_data))
        else $error("retire_data has unknown bits while retire_valid is high");

    // Retire strobe cleared by reset
    reset_clears: assert property (@(posedge CLK) RST |=> !retire_valid)
        else $error("retire_valid high in the cycle after reset");

endmodule

bind single_cycle_cpu cpu_assert u_assert (
    .CLK          (CLK),
    .RST          (RST),
    .run          (run),
    .retire_valid (retire_valid),
    .retire_store (retire_store),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
);

// ==== verification/cpu_tb.sv ====
`include "cpu_params.svh"

module cpu_tb import cpu_pkg::*; ();

    localparam int N_ADDI       = 16;
    localparam int R_ROUNDS     = 3;   // 13 instructions each
    localparam int MEM_PAIRS    = 6;   // 5 instructions each
    localparam int FIXED_INSTRS = 28;  // x0, unknown opcode and pause programs
    localparam int N_TESTS      = 6;
    localparam int TEST_CYCLES  =
        2 * (N_ADDI + 13 * R_ROUNDS + 5 * MEM_PAIRS + FIXED_INSTRS) + 12 * N_TESTS + 4;

    // add sub sll slt sltu xor srl sra or and
    localparam logic [2:0] R_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                         3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    localparam logic [6:0] R_F7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                                         7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
    localparam logic [6:0] BAD_OPS [4] = '{7'b0110111, 7'b1101111, 7'b1110011, 7'b1111111};

    logic                   CLK = 1'b0;
    logic                   RST;
    logic                   run;
    logic                   imem_we;
    logic [`IMEM_AW-1:0]    imem_addr;
    logic [`XLEN-1:0]       imem_wdata;
    logic                   retire_valid;
    logic                   retire_store;
    logic [`REG_ADDR_W-1:0] retire_rd;
    logic [`XLEN-1:0]       retire_data;

    int                     seed;
    int                     value_errors = 0;
    int                     protocol_errors = 0;
    int                     missing_errors = 0;
    logic [`XLEN-1:0]       prog [$];
    decoded_t               exp_ctrl [$];
    logic [`XLEN-1:0]       exp_data [$];
    string                  exp_name [$];
    logic [`XLEN-1:0]       m_regs [`REG_COUNT];  // Reference machine state
    logic [`XLEN-1:0]       m_mem [`DMEM_DEPTH];

    single_cycle_cpu uut (
        .CLK          (CLK),
        .RST          (RST),
        .run          (run),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .retire_valid (retire_valid),
        .retire_store (retire_store),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #5 CLK = ~CLK;

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    // ISA level model of one instruction, returns the reported rd and store flag
    function automatic decoded_t exec_ref(input logic [`XLEN-1:0] ins,
                                          ref logic [`XLEN-1:0] regs [`REG_COUNT],
                                          ref logic [`XLEN-1:0] mem [`DMEM_DEPTH],
                                          output logic [`XLEN-1:0] data);
        decoded_t         d;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] imm_i;
        logic [`XLEN-1:0] imm_s;
        logic [`XLEN-1:0] res;
        logic [`XLEN-1:0] addr;
        logic [4:0]       sh;
        logic [2:0]       f3;
        logic [6:0]       f7;
        d     = '0;
        data  = '0;
        res   = '0;
        f3    = ins[14:12];
        f7    = ins[31:25];
        a     = regs[ins[19:15]];
        b     = regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        sh    = (ins[6:0] == OP_R) ? b[4:0] : ins[24:20];
        case (ins[6:0])
            OP_R, OP_IMM: begin
                if (ins[6:0] == OP_R) begin
                    d.reg_we = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                end else begin
                    d.reg_we = (f3 == 3'd0) || (f3 == 3'd1 && f7 == 7'h00) ||
                               (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20));
                    b = imm_i;
                end
                case (f3)
                    3'd0: res = (ins[6:0] == OP_R && f7[5]) ? a - b : a + b;
                    3'd1: res = a << sh;
                    3'd2: res = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
                    3'd3: res = {{(`XLEN-1){1'b0}}, a < b};
                    3'd4: res = a ^ b;
                    3'd5: begin
                        if (f7[5]) begin
                            res = $signed(a) >>> sh;  // Sign bit fills in
                        end else begin
                            res = a >> sh;
                        end
                    end
                    3'd6: res = a | b;
                    default: res = a & b;
                endcase
            end
            OP_LOAD: begin
                if (f3 == 3'b010) begin
                    addr     = a + imm_i;
                    res      = mem[addr[`DMEM_AW+1:2]];
                    d.reg_we = 1'b1;
                    d.mem_re = 1'b1;
                end
            end
            OP_STORE: begin
                if (f3 == 3'b010) begin
                    addr                    = a + imm_s;
                    mem[addr[`DMEM_AW+1:2]] = b;
                    d.mem_we                = 1'b1;
                    data                    = b;
                end
            end
            default: ;
        endcase
        if (d.reg_we && ins[11:7] != 5'd0) begin
            regs[ins[11:7]] = res;
            d.rd            = ins[11:7];
            data            = res;
        end
        return d;
    endfunction

    task automatic check_reg(input string name, input decoded_t exp,
                             input logic [`REG_ADDR_W-1:0] act_rd,
                             input logic [`XLEN-1:0] exp_val, input logic [`XLEN-1:0] act_val);
        if (act_rd !== exp.rd || act_val !== exp_val) begin
            $display("[FAIL] %s: expected rd=x%0d data=%h, actual rd=x%0d data=%h",
                     name, exp.rd, exp_val, act_rd, act_val);
            value_errors++;
        end
    endtask

    task automatic check_store(input string name, input logic [`XLEN-1:0] exp_val,
                               input logic [`XLEN-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("[FAIL] %s: expected store data %h, actual %h", name, exp_val, act_val);
            value_errors++;
        end
    endtask

    task automatic apply_reset();
        RST <= 1'b1;
        repeat (4) @(posedge CLK);
        RST <= 1'b0;
    endtask

    task automatic run_for(input int n);
        run <= 1'b1;
        repeat (n) @(posedge CLK);
        run <= 1'b0;
    endtask

    task automatic run_test(input string name, input int pause_at);
        decoded_t         e;
        logic [`XLEN-1:0] d;
        int               n;
        n = prog.size();
        for (int i = 0; i < n; i++) begin
            @(posedge CLK);
            imem_we    <= 1'b1;
            imem_addr  <= i[`IMEM_AW-1:0];
            imem_wdata <= prog[i];
        end
        @(posedge CLK);
        imem_we <= 1'b0;
        apply_reset();
        for (int r = 0; r < `REG_COUNT; r++) begin
            m_regs[r] = '0;
        end
        for (int w = 0; w < `DMEM_DEPTH; w++) begin
            m_mem[w] = '0;
        end
        foreach (prog[i]) begin
            e = exec_ref(prog[i], m_regs, m_mem, d);
            exp_ctrl.push_back(e);
            exp_data.push_back(d);
            exp_name.push_back(name);
        end
        if (pause_at > 0 && pause_at < n) begin
            run_for(pause_at);
            repeat (3) @(posedge CLK);  // Halted gap
            run_for(n - pause_at);
        end else begin
            run_for(n);
        end
        repeat (2) @(posedge CLK);  // Last retire is one cycle behind
        if (exp_ctrl.size() != 0) begin
            $display("%s: %0d instruction(s) never retired", name, exp_ctrl.size());
            missing_errors++;
            exp_ctrl.delete();
            exp_data.delete();
            exp_name.delete();
        end
        prog.delete();
    endtask

    task automatic gen_addi();
        logic [31:0] r;
        for (int i = 1; i <= N_ADDI; i++) begin
            r = rnd();
            prog.push_back(enc_i(r[11:0], 5'(i - 1), 3'd0, 5'(i), OP_IMM));
        end
    endtask

    task automatic gen_rtype();
        logic [31:0] r;
        for (int n = 0; n < R_ROUNDS; n++) begin
            r = rnd();
            prog.push_back(enc_i(r[11:0], 5'd0, 3'd0, 5'd1, OP_IMM));
            prog.push_back(enc_i(r[23:12], 5'd0, 3'd0, 5'd2, OP_IMM));
            prog.push_back(enc_i({7'h00, r[28:24]}, 5'd1, 3'd1, 5'd1, OP_IMM));  // Widen x1
            for (int k = 0; k < 10; k++) begin
                prog.push_back(enc_r(R_F7[k], n[0] ? 5'd1 : 5'd2, n[0] ? 5'd2 : 5'd1,
                                     R_F3[k], 5'(3 + k)));
            end
        end
    endtask

    task automatic gen_mem();
        logic [31:0] r;
        logic [11:0] off;
        for (int n = 0; n < MEM_PAIRS; n++) begin
            r   = rnd();
            off = {7'h00, r[27:25], 2'b00};
            prog.push_back(enc_i({2'b00, r[7:0], 2'b00}, 5'd0, 3'd0, 5'd5, OP_IMM));
            prog.push_back(enc_i(r[19:8], 5'd0, 3'd0, 5'd6, OP_IMM));
            prog.push_back(enc_i({7'h00, r[24:20]}, 5'd6, 3'd1, 5'd6, OP_IMM));
            prog.push_back(enc_s(off, 5'd6, 5'd5, 3'b010));
            prog.push_back(enc_i(off, 5'd5, 3'b010, 5'd7, OP_LOAD));
        end
    endtask

    task automatic gen_x0();
        logic [31:0] r;
        r = rnd();
        prog.push_back(enc_i(r[11:0] | 12'h001, 5'd0, 3'd0, 5'd0, OP_IMM));
        prog.push_back(enc_i(r[23:12], 5'd0, 3'd0, 5'd1, OP_IMM));
        prog.push_back(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd0));
        prog.push_back(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd3));  // Reads x0 back
        prog.push_back(enc_r(7'h20, 5'd0, 5'd1, 3'd0, 5'd4));
        prog.push_back(enc_i(12'h000, 5'd0, 3'b010, 5'd0, OP_LOAD));
    endtask

    task automatic gen_unknown();
        logic [31:0] r;
        r = rnd();
        prog.push_back(enc_i(r[11:0], 5'd0, 3'd0, 5'd1, OP_IMM));
        for (int i = 0; i < 3; i++) begin
            r = rnd();
            prog.push_back({r[31:7], BAD_OPS[r[1:0]]});
        end
        prog.push_back(enc_r(7'h20, 5'd1, 5'd1, 3'd1, 5'd2));
        prog.push_back(enc_i(12'h000, 5'd0, 3'd0, 5'd3, OP_LOAD));  // lb
        prog.push_back(enc_s(12'h000, 5'd1, 5'd0, 3'd0));  // sb
        prog.push_back(enc_i({7'h20, 5'd3}, 5'd1, 3'd1, 5'd4, OP_IMM));
        prog.push_back(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd5));
        prog.push_back(enc_i(12'h000, 5'd0, 3'b010, 5'd6, OP_LOAD));
    endtask

    task automatic gen_pause();
        logic [31:0] r;
        r = rnd();
        prog.push_back(enc_i(r[11:0], 5'd0, 3'd0, 5'd1, OP_IMM));
        for (int i = 2; i <= 12; i++) begin
            prog.push_back(enc_r(7'h00, 5'd1, 5'(i - 1), 3'd0, 5'(i)));
        end
    endtask

    always @(posedge CLK) begin : compare
        decoded_t         e;
        logic [`XLEN-1:0] d;
        string            nm;
        if (!RST && retire_valid === 1'b1) begin
            if (exp_ctrl.size() == 0) begin
                $display("Unexpected retire at time %0t with nothing outstanding", $time);
                protocol_errors++;
            end else begin
                e  = exp_ctrl.pop_front();
                d  = exp_data.pop_front();
                nm = exp_name.pop_front();
                if (e.mem_we) begin
                    if (retire_store !== 1'b1) begin
                        $display("%s: a store retired without retire_store", nm);
                        protocol_errors++;
                    end
                    if (retire_rd !== '0) begin
                        $display("[FAIL] %s: store rd expected 0, actual %0d", nm, retire_rd);
                        value_errors++;
                    end
                    check_store(nm, d, retire_data);
                end else begin
                    if (retire_store !== 1'b0) begin
                        $display("%s: retire_store set on a non-store", nm);
                        protocol_errors++;
                    end
                    check_reg(nm, e, retire_rd, d, retire_data);
                end
            end
        end
    end

    initial begin
        #(TEST_CYCLES * 10 * 2 + 1000);
        $display("Watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        RST        = 1'b1;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        seed       = 27231;
        repeat (4) @(posedge CLK);
        RST <= 1'b0;
        gen_addi();
        run_test("addi_chain", 0);
        gen_rtype();
        run_test("rtype_ops", 0);
        gen_mem();
        run_test("store_load", 0);
        gen_x0();
        run_test("x0_writes", 0);
        gen_unknown();
        run_test("unknown_ops", 0);
        gen_pause();
        run_test("pause_resume", 5);
        $display("Errors: %0d value, %0d protocol, %0d missing",
                 value_errors, protocol_errors, missing_errors);
        if (value_errors + protocol_errors + missing_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+common
common/cpu_pkg.sv
common/dec_if.sv
hw/fetch_stage.sv
hw/register_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/single_cycle_cpu.sv
verification/cpu_assert.sv
verification/cpu_tb.sv

// ==== Makefile ====
TOP = cpu_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation into sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
